/* src/sys86_pkg.sv */
package sys86_pkg;

	////////////////////
	// CPU side
	////////////////////

	// One bus cycle as the processor presents it
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        we;
	} cpu_bus_t;

	// Decoded destinations of a CPU access
	typedef enum logic [3:0] {
		REG_NONE,
		REG_SCROLL0,
		REG_SCROLL1,
		REG_OBJECT,
		REG_LATCH0,
		REG_LATCH1,
		REG_BACKCOLOR,
		REG_IRQ_ACK,
		REG_ROM_LO,
		REG_ROM_HI
	} region_e;

	// Captured request, held until the slot owner completes it
	typedef struct packed {
		logic        valid;
		region_e     region;
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        we;
	} decode_t;

	////////////////////
	// Address map
	////////////////////

	// Values of address bits 15-13
	localparam logic [2:0] PAGE_VIDEO_LO = 3'b000;
	localparam logic [2:0] PAGE_OBJECT   = 3'b001;
	localparam logic [2:0] PAGE_LATCH    = 3'b011;

endpackage

/* src/phase_gen.sv */
`timescale 1ns/1ps

module phase_gen #(
	parameter int N_CPU  = 2,
	parameter int SLOT_W = 1
) (
	input  logic              clk_6m,
	input  logic              rst,
	input  logic              vblank_n,
	output logic [SLOT_W-1:0] slot,
	output logic              slot_start,
	output logic              slot_act,
	output logic              vblank_start
);

	logic half;
	logic vblank_q;

	// Two clocks per slot, owners in turn
	always_ff @(posedge clk_6m) begin
		if (rst) begin
			half <= 1'b0;
			slot <= '0;
		end else begin
			half <= ~half;
			if (half) begin
				if (slot == SLOT_W'(N_CPU - 1)) begin
					slot <= '0;
				end else begin
					slot <= slot + 1'b1;
				end
			end
		end
	end

	assign slot_start = ~half;
	assign slot_act   = half;

	// Falling edge of vblank_n
	always_ff @(posedge clk_6m) begin
		if (rst) begin
			vblank_q <= 1'b1;
		end else begin
			vblank_q <= vblank_n;
		end
	end

	assign vblank_start = vblank_q & ~vblank_n;

	a_slot_range: assert property (@(posedge clk_6m) disable iff (rst)
		slot < N_CPU)
		else $error("slot index past last CPU");

endmodule

/* src/cpu_decoder.sv */
`timescale 1ns/1ps

module cpu_decoder (
	input  logic               clk_6m,
	input  logic               rst,
	input  logic               slot_start,
	input  logic               own_slot,
	input  logic               vblank_start,
	input  logic               req,
	input  sys86_pkg::cpu_bus_t bus,
	input  logic               done,
	output sys86_pkg::decode_t  dec,
	output logic               irq
);

	import sys86_pkg::*;

	decode_t dec_q;
	logic    wait_drop;
	logic    capture;
	logic    irq_ack;

	// Region from the CPU address
	function automatic region_e classify(input logic [15:0] a);
		region_e r;
		r = REG_NONE;
		if (a[15]) begin
			r = a[14] ? REG_ROM_HI : REG_ROM_LO;
		end else begin
			case (a[15:13])
				PAGE_VIDEO_LO: r = a[12] ? REG_SCROLL1 : REG_SCROLL0;
				PAGE_OBJECT:   r = REG_OBJECT;
				PAGE_LATCH: begin
					case (a[1:0])
						2'd0:    r = REG_LATCH0;
						2'd1:    r = REG_LATCH1;
						2'd2:    r = REG_BACKCOLOR;
						default: r = REG_IRQ_ACK;
					endcase
				end
				default:       r = REG_NONE;
			endcase
		end
		return r;
	endfunction

	assign capture = slot_start & own_slot & req & ~dec_q.valid & ~wait_drop;

	// Request latch
	always_ff @(posedge clk_6m) begin
		if (rst) begin
			dec_q.valid <= 1'b0;
		end else begin
			if (done) begin
				dec_q.valid <= 1'b0;
			end
			if (capture) begin
				dec_q.valid  <= 1'b1;
				dec_q.region <= classify(bus.addr);
				dec_q.addr   <= bus.addr;
				dec_q.wdata  <= bus.wdata;
				dec_q.we     <= bus.we;
			end
		end
	end

	// CPU must drop req before the next capture
	always_ff @(posedge clk_6m) begin
		if (rst) begin
			wait_drop <= 1'b0;
		end else if (done) begin
			wait_drop <= req;
		end else if (!req) begin
			wait_drop <= 1'b0;
		end
	end

	assign irq_ack = done & dec_q.we & (dec_q.region == REG_IRQ_ACK);

	// Vblank wins over a simultaneous ack
	always_ff @(posedge clk_6m) begin
		if (rst) begin
			irq <= 1'b0;
		end else if (vblank_start) begin
			irq <= 1'b1;
		end else if (irq_ack) begin
			irq <= 1'b0;
		end
	end

	assign dec = dec_q;

	a_done_valid: assert property (@(posedge clk_6m) disable iff (rst)
		done |-> dec_q.valid)
		else $error("done with no captured request");

endmodule

/* src/bus_mux.sv */
`timescale 1ns/1ps

module bus_mux #(
	parameter int N_CPU  = 2,
	parameter int SLOT_W = 1
) (
	input  logic                  clk_6m,
	input  logic                  rst,
	input  logic [SLOT_W-1:0]     slot,
	input  logic                  slot_act,
	input  sys86_pkg::decode_t    dec [N_CPU],
	input  logic [7:0]            vdata_in,
	input  logic [7:0]            rom_data,
	output logic [12:0]           vaddr,
	output logic [7:0]            vdata_out,
	output logic                  vwe_n,
	output logic                  scroll0_n,
	output logic                  scroll1_n,
	output logic                  object_n,
	output logic                  latch0_n,
	output logic                  latch1_n,
	output logic                  backcolor_n,
	output logic [7:0]            md,
	output logic [N_CPU-1:0]      cpu_done,
	output logic [N_CPU-1:0][7:0] cpu_rdata
);

	import sys86_pkg::*;

	decode_t    owner;
	logic       active;
	logic       on_bus;
	logic       is_rom;
	logic [7:0] read_byte;

	assign owner  = dec[slot];
	assign active = slot_act & owner.valid;
	assign is_rom = (owner.region == REG_ROM_LO) || (owner.region == REG_ROM_HI);

	// Regions that reach the shared video bus
	always_comb begin
		case (owner.region)
			REG_SCROLL0, REG_SCROLL1, REG_OBJECT,
			REG_LATCH0, REG_LATCH1, REG_BACKCOLOR: on_bus = 1'b1;
			default:                               on_bus = 1'b0;
		endcase
	end

	////////////////////
	// Video bus side
	////////////////////

	assign vaddr     = owner.addr[12:0];
	assign vdata_out = owner.wdata;
	assign vwe_n     = ~(active & on_bus & owner.we);

	assign scroll0_n   = ~(active && owner.region == REG_SCROLL0);
	assign scroll1_n   = ~(active && owner.region == REG_SCROLL1);
	assign object_n    = ~(active && owner.region == REG_OBJECT);
	assign latch0_n    = ~(active && owner.region == REG_LATCH0);
	assign latch1_n    = ~(active && owner.region == REG_LATCH1);
	assign backcolor_n = ~(active && owner.region == REG_BACKCOLOR);

	// Back color latch
	always_ff @(posedge clk_6m) begin
		if (rst) begin
			md <= 8'h00;
		end else if (active && owner.we && owner.region == REG_BACKCOLOR) begin
			md <= owner.wdata;
		end
	end

	////////////////////
	// Return to CPUs
	////////////////////

	always_comb begin
		read_byte = 8'h00;
		if (!owner.we) begin
			if (is_rom) begin
				read_byte = rom_data;
			end else if (on_bus) begin
				read_byte = vdata_in;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < N_CPU; i++) begin
			cpu_done[i]  = active && (slot == SLOT_W'(i));
			cpu_rdata[i] = cpu_done[i] ? read_byte : 8'h00;
		end
	end

	a_one_strobe: assert property (@(posedge clk_6m) disable iff (rst)
		$onehot0(~{scroll0_n, scroll1_n, object_n, latch0_n, latch1_n, backcolor_n}))
		else $error("more than one chip strobe low");

endmodule

/* src/rom_port.sv */
`timescale 1ns/1ps

module rom_port #(
	parameter int N_CPU  = 2,
	parameter int SLOT_W = 1
) (
	input  logic               clk_6m,
	input  logic               rst,
	input  logic [SLOT_W-1:0]  slot,
	input  logic               slot_act,
	input  sys86_pkg::decode_t dec [N_CPU],
	output logic [14:0]        rom_addr,
	output logic [SLOT_W:0]    rom_bank,
	output logic               rom_ce_n
);

	import sys86_pkg::*;

	decode_t owner;
	logic    is_rom;
	logic    hi_bank;

	assign owner   = dec[slot];
	assign hi_bank = (owner.region == REG_ROM_HI);
	assign is_rom  = (owner.region == REG_ROM_LO) || hi_bank;

	// Bank is owner index with the LO/HI half below it
	assign rom_addr = owner.addr[14:0];
	assign rom_bank = {slot, hi_bank};

	// Reads only, a ROM write completes without touching the chip
	assign rom_ce_n = ~(slot_act & owner.valid & is_rom & ~owner.we);

	a_ce_single: assert property (@(posedge clk_6m) disable iff (rst)
		!rom_ce_n |=> rom_ce_n)
		else $error("rom_ce_n low for more than one cycle");

endmodule

/* src/cpu_subsystem.sv */
`timescale 1ns/1ps

module cpu_subsystem #(
	parameter int N_CPU  = 2,
	parameter int SLOT_W = (N_CPU > 1) ? $clog2(N_CPU) : 1
) (
	input  logic                           clk_6m,
	input  logic                           rst,

	// CPU buses
	input  sys86_pkg::cpu_bus_t [N_CPU-1:0] cpu_bus,
	input  logic [N_CPU-1:0]               cpu_req,
	output logic [N_CPU-1:0]               cpu_done,
	output logic [N_CPU-1:0][7:0]          cpu_rdata,
	output logic [N_CPU-1:0]               irq,

	// Shared video bus
	input  logic [7:0]                     vdata_in,
	input  logic                           vblank_n,
	output logic [12:0]                    vaddr,
	output logic [7:0]                     vdata_out,
	output logic                           vwe_n,
	output logic                           scroll0_n,
	output logic                           scroll1_n,
	output logic                           object_n,
	output logic                           latch0_n,
	output logic                           latch1_n,
	output logic [7:0]                     md,
	output logic                           backcolor_n,

	// Program ROM
	output logic [14:0]                    rom_addr,
	output logic [SLOT_W:0]                rom_bank,
	output logic                           rom_ce_n,
	input  logic [7:0]                     rom_data
);

	import sys86_pkg::*;

	logic [SLOT_W-1:0] slot;
	logic              slot_start;
	logic              slot_act;
	logic              vblank_start;
	decode_t           dec_bus [N_CPU];

	phase_gen #(
		.N_CPU  (N_CPU),
		.SLOT_W (SLOT_W)
	) u_phase_gen (
		.clk_6m       (clk_6m),
		.rst          (rst),
		.vblank_n     (vblank_n),
		.slot         (slot),
		.slot_start   (slot_start),
		.slot_act     (slot_act),
		.vblank_start (vblank_start)
	);

	// One decoder per CPU
	for (genvar i = 0; i < N_CPU; i++) begin : g_cpu
		cpu_decoder u_cpu_decoder (
			.clk_6m       (clk_6m),
			.rst          (rst),
			.slot_start   (slot_start),
			.own_slot     (slot == SLOT_W'(i)),
			.vblank_start (vblank_start),
			.req          (cpu_req[i]),
			.bus          (cpu_bus[i]),
			.done         (cpu_done[i]),
			.dec          (dec_bus[i]),
			.irq          (irq[i])
		);
	end

	bus_mux #(
		.N_CPU  (N_CPU),
		.SLOT_W (SLOT_W)
	) u_bus_mux (
		.clk_6m      (clk_6m),
		.rst         (rst),
		.slot        (slot),
		.slot_act    (slot_act),
		.dec         (dec_bus),
		.vdata_in    (vdata_in),
		.rom_data    (rom_data),
		.vaddr       (vaddr),
		.vdata_out   (vdata_out),
		.vwe_n       (vwe_n),
		.scroll0_n   (scroll0_n),
		.scroll1_n   (scroll1_n),
		.object_n    (object_n),
		.latch0_n    (latch0_n),
		.latch1_n    (latch1_n),
		.backcolor_n (backcolor_n),
		.md          (md),
		.cpu_done    (cpu_done),
		.cpu_rdata   (cpu_rdata)
	);

	rom_port #(
		.N_CPU  (N_CPU),
		.SLOT_W (SLOT_W)
	) u_rom_port (
		.clk_6m   (clk_6m),
		.rst      (rst),
		.slot     (slot),
		.slot_act (slot_act),
		.dec      (dec_bus),
		.rom_addr (rom_addr),
		.rom_bank (rom_bank),
		.rom_ce_n (rom_ce_n)
	);

endmodule

/* bench/tb_cpu_subsystem.sv */
`timescale 1ns/1ps

module tb_cpu_subsystem;

	import sys86_pkg::*;

	localparam int N_CPU  = 2;
	localparam int BANK_W = 2;

	// One CPU request with the region it must land in
	typedef struct packed {
		logic [1:0]  cpu;
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        we;
		region_e     region;
		logic        pair;
		logic        vbl;
	} stim_t;

	logic                  clk_6m = 1'b0;
	logic                  rst;
	cpu_bus_t [N_CPU-1:0]  cpu_bus;
	logic [N_CPU-1:0]      cpu_req;
	logic [N_CPU-1:0]      cpu_done;
	logic [N_CPU-1:0][7:0] cpu_rdata;
	logic [N_CPU-1:0]      irq;
	logic [7:0]            vdata_in;
	logic                  vblank_n;
	logic [12:0]           vaddr;
	logic [7:0]            vdata_out;
	logic                  vwe_n;
	logic                  scroll0_n;
	logic                  scroll1_n;
	logic                  object_n;
	logic                  latch0_n;
	logic                  latch1_n;
	logic [7:0]            md;
	logic                  backcolor_n;
	logic [14:0]           rom_addr;
	logic [BANK_W-1:0]     rom_bank;
	logic                  rom_ce_n;
	logic [7:0]            rom_data;

	stim_t            stim [$];
	int               pend [N_CPU];
	int               waited [N_CPU];
	logic [N_CPU-1:0] irq_exp;
	logic [7:0]       md_exp;
	logic [31:0]      rng;
	int               cycles = 0;
	int               limit;

	always #2 clk_6m = ~clk_6m;

	cpu_subsystem #(
		.N_CPU (N_CPU)
	) u_cpu_subsystem (
		.clk_6m      (clk_6m),
		.rst         (rst),
		.cpu_bus     (cpu_bus),
		.cpu_req     (cpu_req),
		.cpu_done    (cpu_done),
		.cpu_rdata   (cpu_rdata),
		.irq         (irq),
		.vdata_in    (vdata_in),
		.vblank_n    (vblank_n),
		.vaddr       (vaddr),
		.vdata_out   (vdata_out),
		.vwe_n       (vwe_n),
		.scroll0_n   (scroll0_n),
		.scroll1_n   (scroll1_n),
		.object_n    (object_n),
		.latch0_n    (latch0_n),
		.latch1_n    (latch1_n),
		.md          (md),
		.backcolor_n (backcolor_n),
		.rom_addr    (rom_addr),
		.rom_bank    (rom_bank),
		.rom_ce_n    (rom_ce_n),
		.rom_data    (rom_data)
	);

	////////////////////
	// Models
	////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Low byte folded with upper address bits and a per-bank key
	function automatic logic [7:0] rom_byte(input logic [BANK_W-1:0] bank, input logic [14:0] a);
		return a[7:0] ^ {1'b0, a[14:8]} ^ ({4{bank}} ^ 8'h5a);
	endfunction

	assign rom_data = rom_ce_n ? 8'hff : rom_byte(rom_bank, rom_addr);

	// Active low, scroll0 first and backcolor last
	function automatic logic [5:0] strobe_pattern(input region_e r);
		case (r)
			REG_SCROLL0:   return 6'b011111;
			REG_SCROLL1:   return 6'b101111;
			REG_OBJECT:    return 6'b110111;
			REG_LATCH0:    return 6'b111011;
			REG_LATCH1:    return 6'b111101;
			REG_BACKCOLOR: return 6'b111110;
			default:       return 6'b111111;
		endcase
	endfunction

	task automatic stop_failed();
		$display("*** FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
		stop_failed();
	endtask

	task automatic text_error(input string msg);
		$display("%s", msg);
		stop_failed();
	endtask

	task automatic add_entry(input logic [1:0] cpu, input logic [15:0] addr,
		input logic [7:0] wdata, input logic we, input region_e region,
		input logic pair, input logic vbl);
		stim_t s;
		s = '{cpu, addr, wdata, we, region, pair, vbl};
		stim.push_back(s);
	endtask

	function automatic logic busy();
		logic b;
		b = 1'b0;
		for (int c = 0; c < N_CPU; c++) begin
			b = b | (pend[c] >= 0);
		end
		return b;
	endfunction

	////////////////////
	// Per-cycle checks
	////////////////////

	// Sample first, then step the video data and vblank
	task automatic check_cycle();
		stim_t            e;
		logic [5:0]       strb_exp;
		logic             vwe_exp;
		logic             ce_exp;
		logic [7:0]       rd_exp;
		logic [7:0]       md_next;
		logic [N_CPU-1:0] irq_next;
		strb_exp = 6'h3f;
		vwe_exp  = 1'b1;
		ce_exp   = 1'b1;
		md_next  = md_exp;
		irq_next = irq_exp;
		assert ($onehot0(cpu_done)) else text_error("two CPUs completed in the same cycle");
		assert (irq === irq_exp) else value_error("irq", 32'(irq), 32'(irq_exp));
		assert (md === md_exp) else value_error("md", 32'(md), 32'(md_exp));
		for (int c = 0; c < N_CPU; c++) begin
			if (cpu_done[c] === 1'b1) begin
				assert (pend[c] >= 0) else text_error("cpu_done pulsed with no request pending");
				e        = stim[pend[c]];
				strb_exp = strobe_pattern(e.region);
				rd_exp   = 8'h00;
				if (strb_exp != 6'h3f) begin
					vwe_exp = ~e.we;
					assert (vaddr === e.addr[12:0])
						else value_error("vaddr", 32'(vaddr), 32'(e.addr[12:0]));
					if (e.we) begin
						assert (vdata_out === e.wdata)
							else value_error("vdata_out", 32'(vdata_out), 32'(e.wdata));
					end else begin
						rd_exp = vdata_in;
					end
				end else if ((e.region == REG_ROM_LO || e.region == REG_ROM_HI) && !e.we) begin
					ce_exp = 1'b0;
					rd_exp = rom_byte({c[0], e.addr[14]}, e.addr[14:0]);
				end
				assert (cpu_rdata[c] === rd_exp)
					else value_error($sformatf("cpu_rdata[%0d]", c), 32'(cpu_rdata[c]), 32'(rd_exp));
				if (e.we && e.region == REG_BACKCOLOR) begin
					md_next = e.wdata;
				end
				if (e.we && e.region == REG_IRQ_ACK) begin
					irq_next[c] = 1'b0;
				end
				cpu_req[c] = 1'b0;
				pend[c]    = -1;
			end else if (pend[c] >= 0) begin
				waited[c]++;
				assert (waited[c] <= 2 * N_CPU) else text_error("request not completed within its slot rotation");
			end
		end
		assert ({scroll0_n, scroll1_n, object_n, latch0_n, latch1_n, backcolor_n} === strb_exp)
			else value_error("scroll0_n..backcolor_n",
				32'({scroll0_n, scroll1_n, object_n, latch0_n, latch1_n, backcolor_n}), 32'(strb_exp));
		assert (vwe_n === vwe_exp) else value_error("vwe_n", 32'(vwe_n), 32'(vwe_exp));
		assert (rom_ce_n === ce_exp) else value_error("rom_ce_n", 32'(rom_ce_n), 32'(ce_exp));
		md_exp   = md_next;
		irq_exp  = irq_next;
		rng      = xorshift(rng);
		vdata_in = rng[7:0];
		vblank_n = 1'b1;
	endtask

	task automatic load_table();
		// cpu, addr, wdata, we, region, issue with next, vblank edge
		add_entry(0, 16'h0123, 8'h00, 0, REG_SCROLL0,   0, 0);
		add_entry(1, 16'h1abc, 8'h3c, 1, REG_SCROLL1,   0, 0);
		add_entry(0, 16'h2f0e, 8'h77, 1, REG_OBJECT,    0, 0);
		add_entry(1, 16'h3001, 8'h00, 0, REG_OBJECT,    0, 0);
		add_entry(0, 16'h6000, 8'h11, 1, REG_LATCH0,    0, 0);
		add_entry(1, 16'h7ff1, 8'h22, 1, REG_LATCH1,    0, 0);
		add_entry(0, 16'h6002, 8'ha5, 1, REG_BACKCOLOR, 0, 0);
		add_entry(1, 16'h6006, 8'h00, 0, REG_BACKCOLOR, 0, 0);
		add_entry(0, 16'h8345, 8'h00, 0, REG_ROM_LO,    0, 0);
		add_entry(1, 16'hc2f7, 8'h00, 0, REG_ROM_HI,    0, 0);
		add_entry(0, 16'hd000, 8'h99, 1, REG_ROM_HI,    0, 0);
		add_entry(1, 16'h4000, 8'h12, 1, REG_NONE,      0, 0);
		add_entry(0, 16'h0100, 8'h00, 0, REG_SCROLL0,   0, 1);
		add_entry(1, 16'h6003, 8'h00, 1, REG_IRQ_ACK,   0, 0);
		add_entry(0, 16'h6007, 8'h00, 1, REG_IRQ_ACK,   1, 0);
		add_entry(1, 16'h6012, 8'h5e, 1, REG_BACKCOLOR, 0, 0);
		add_entry(0, 16'h1fff, 8'hc3, 1, REG_SCROLL1,   1, 0);
		add_entry(1, 16'h8001, 8'h00, 0, REG_ROM_LO,    0, 0);
		add_entry(0, 16'ha000, 8'h00, 0, REG_ROM_LO,    1, 0);
		add_entry(1, 16'h6002, 8'h0f, 1, REG_BACKCOLOR, 0, 0);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		stim_t e;
		int    idx;
		load_table();
		limit    = stim.size() * (2 * N_CPU + 2) + 50;
		rst      = 1'b1;
		cpu_req  = '0;
		cpu_bus  = '0;
		rng      = 32'h6ce1;
		vdata_in = rng[7:0];
		vblank_n = 1'b1;
		md_exp   = 8'h00;
		irq_exp  = '0;
		for (int c = 0; c < N_CPU; c++) begin
			pend[c]   = -1;
			waited[c] = 0;
		end
		repeat (2) @(negedge clk_6m);
		// Idle outputs while still in reset
		check_cycle();
		rst = 1'b0;
		idx = 0;
		while (idx < stim.size()) begin
			@(negedge clk_6m);
			check_cycle();
			// One entry or a pair issued in the same cycle
			do begin
				e = stim[idx];
				pend[e.cpu]          = idx;
				waited[e.cpu]        = 0;
				cpu_bus[e.cpu].addr  = e.addr;
				cpu_bus[e.cpu].wdata = e.wdata;
				cpu_bus[e.cpu].we    = e.we;
				cpu_req[e.cpu]       = 1'b1;
				if (e.vbl) begin
					vblank_n = 1'b0;
					irq_exp  = '1;
				end
				idx++;
			end while (e.pair && idx < stim.size());
			while (busy()) begin
				@(negedge clk_6m);
				check_cycle();
			end
		end
		repeat (4) begin
			@(negedge clk_6m);
			check_cycle();
		end
		$display("*** PASSED ***");
		$finish;
	end

	always @(posedge clk_6m) begin
		cycles++;
		if (cycles > limit) begin
			text_error($sformatf("timeout after %0d cycles", cycles));
		end
	end

endmodule

/* cpu_subsystem.f */
src/sys86_pkg.sv
src/phase_gen.sv
src/cpu_decoder.sv
src/bus_mux.sv
src/rom_port.sv
src/cpu_subsystem.sv
bench/tb_cpu_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_subsystem \
	-f cpu_subsystem.f -o sim_tb > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
